// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module memory_game_tb -f memory_game.f -Mdir obj_dir
	@out=$$(./obj_dir/Vmemory_game_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== hdl/hex_to_seven_segment.sv ====
// Active-low outputs ordered {g, f, e, d, c, b, a}; letters b and d show in lower case
`timescale 1ns/100ps

module hex_to_seven_segment (
    input  logic [3:0]                 value,
    output memory_game_pkg::segments_t segments
);

    always_comb begin
        case (value)
            4'h0:    segments = 7'b1000000;
            4'h1:    segments = 7'b1111001;
            4'h2:    segments = 7'b0100100;
            4'h3:    segments = 7'b0110000;
            4'h4:    segments = 7'b0011001;
            4'h5:    segments = 7'b0010010;
            4'h6:    segments = 7'b0000010;
            4'h7:    segments = 7'b1111000;
            4'h8:    segments = 7'b0000000;
            4'h9:    segments = 7'b0010000;
            4'hA:    segments = 7'b0001000;
            4'hB:    segments = 7'b0000011;
            4'hC:    segments = 7'b1000110;
            4'hD:    segments = 7'b0100001;
            4'hE:    segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end

endmodule

// ==== hdl/memory_game.sv ====
// Buttons must be clean levels; the debug displays show state, address and round in hex
`timescale 1ns/100ps

module memory_game (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       play,
    input  memory_game_pkg::button_t   buttons,
    output logic                       won,
    output logic                       lost,
    output logic                       timeout,
    output logic                       ready,
    output memory_game_pkg::button_t   leds,
    output memory_game_pkg::segments_t db_state,
    output memory_game_pkg::segments_t db_address,
    output memory_game_pkg::segments_t db_round
);

    // Control to datapath
    logic clear_address;
    logic count_address;
    logic clear_round;
    logic count_round;
    logic clear_press_timer;
    logic clear_preview_timer;
    logic store_press;
    logic preview;

    // Datapath to control
    logic press_seen;
    logic press_match;
    logic address_at_round;
    logic last_round;
    logic preview_on_done;
    logic preview_off_done;
    logic press_timeout;

    memory_game_pkg::address_t address;
    memory_game_pkg::round_t   round;
    memory_game_pkg::state_t   state;

    // ------------------------------------------------------------
    // Datapath and control unit
    // ------------------------------------------------------------
    memory_game_datapath datapath_i (
        .clock               (clock),
        .reset               (reset),
        .buttons             (buttons),
        .clear_address       (clear_address),
        .count_address       (count_address),
        .clear_round         (clear_round),
        .count_round         (count_round),
        .clear_press_timer   (clear_press_timer),
        .clear_preview_timer (clear_preview_timer),
        .store_press         (store_press),
        .preview             (preview),
        .press_seen          (press_seen),
        .press_match         (press_match),
        .address_at_round    (address_at_round),
        .last_round          (last_round),
        .preview_on_done     (preview_on_done),
        .preview_off_done    (preview_off_done),
        .press_timeout       (press_timeout),
        .leds                (leds),
        .address             (address),
        .round               (round)
    );

    memory_game_control control_i (
        .clock               (clock),
        .reset               (reset),
        .play                (play),
        .press_seen          (press_seen),
        .press_match         (press_match),
        .address_at_round    (address_at_round),
        .last_round          (last_round),
        .preview_on_done     (preview_on_done),
        .preview_off_done    (preview_off_done),
        .press_timeout       (press_timeout),
        .clear_address       (clear_address),
        .count_address       (count_address),
        .clear_round         (clear_round),
        .count_round         (count_round),
        .clear_press_timer   (clear_press_timer),
        .clear_preview_timer (clear_preview_timer),
        .store_press         (store_press),
        .preview             (preview),
        .won                 (won),
        .lost                (lost),
        .timeout             (timeout),
        .ready               (ready),
        .state               (state)
    );

    // ------------------------------------------------------------
    // Debug displays
    // ------------------------------------------------------------
    hex_to_seven_segment state_display_i (
        .value    (state),
        .segments (db_state)
    );

    hex_to_seven_segment address_display_i (
        .value    (address),
        .segments (db_address)
    );

    hex_to_seven_segment round_display_i (
        .value    (round),
        .segments (db_round)
    );

endmodule

// ==== hdl/memory_game_config.svh ====
// Game timing in clock cycles; MG_ROUNDS must stay between 1 and 15 to fit round_t
`ifndef MEMORY_GAME_CONFIG_SVH
`define MEMORY_GAME_CONFIG_SVH

// ------------------------------------------------------------
// Game length
// ------------------------------------------------------------

// Rounds to win, also the longest replayed sequence
`define MG_ROUNDS 6

// ------------------------------------------------------------
// Preview timing
// ------------------------------------------------------------

// Cycles each LED stays lit
`define MG_PREVIEW_ON 8

// Dark cycles between two entries
`define MG_PREVIEW_OFF 4

// ------------------------------------------------------------
// Player timing
// ------------------------------------------------------------

// Cycles allowed without a press
`define MG_TIMEOUT 200

`endif

// ==== hdl/memory_game_control.sv ====
// Play is honoured only in idle or a final state; outcome levels hold until the next play
`timescale 1ns/100ps

module memory_game_control (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     play,
    input  logic                     press_seen,
    input  logic                     press_match,
    input  logic                     address_at_round,
    input  logic                     last_round,
    input  logic                     preview_on_done,
    input  logic                     preview_off_done,
    input  logic                     press_timeout,
    output logic                     clear_address,
    output logic                     count_address,
    output logic                     clear_round,
    output logic                     count_round,
    output logic                     clear_press_timer,
    output logic                     clear_preview_timer,
    output logic                     store_press,
    output logic                     preview,
    output logic                     won,
    output logic                     lost,
    output logic                     timeout,
    output logic                     ready,
    output memory_game_pkg::state_t  state
);

    memory_game_pkg::state_t next_state;
    logic start;

    assign start = play && (state == memory_game_pkg::idle
                         || state == memory_game_pkg::won
                         || state == memory_game_pkg::lost
                         || state == memory_game_pkg::timed_out);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= memory_game_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------
    // Next state and datapath strobes
    // ------------------------------------------------------------
    always_comb begin
        next_state          = state;
        clear_address       = 1'b0;
        count_address       = 1'b0;
        clear_round         = 1'b0;
        count_round         = 1'b0;
        clear_press_timer   = 1'b0;
        clear_preview_timer = 1'b0;
        store_press         = 1'b0;
        preview             = (state == memory_game_pkg::preview_show)
                           || (state == memory_game_pkg::preview_gap);

        case (state)
            memory_game_pkg::prepare: begin
                clear_address       = 1'b1;
                clear_round         = 1'b1;
                clear_press_timer   = 1'b1;
                clear_preview_timer = 1'b1;
                next_state          = memory_game_pkg::preview_show;
            end
            memory_game_pkg::preview_show: begin
                if (preview_on_done) begin
                    next_state = memory_game_pkg::preview_gap;
                end
            end
            // Timer wraps to zero here, so the next entry starts a fresh period
            memory_game_pkg::preview_gap: begin
                if (preview_off_done && address_at_round) begin
                    clear_address     = 1'b1;
                    clear_press_timer = 1'b1;
                    next_state        = memory_game_pkg::wait_press;
                end else if (preview_off_done) begin
                    count_address = 1'b1;
                    next_state    = memory_game_pkg::preview_show;
                end
            end
            memory_game_pkg::wait_press: begin
                if (press_timeout) begin
                    next_state = memory_game_pkg::timed_out;
                end else if (press_seen) begin
                    store_press = 1'b1;
                    next_state  = memory_game_pkg::check;
                end
            end
            memory_game_pkg::check: begin
                if (!press_match) begin
                    next_state = memory_game_pkg::lost;
                end else if (!address_at_round) begin
                    next_state = memory_game_pkg::next_entry;
                end else if (last_round) begin
                    next_state = memory_game_pkg::won;
                end else begin
                    next_state = memory_game_pkg::next_round;
                end
            end
            memory_game_pkg::next_entry: begin
                count_address     = 1'b1;
                clear_press_timer = 1'b1;
                next_state        = memory_game_pkg::wait_press;
            end
            memory_game_pkg::next_round: begin
                count_round         = 1'b1;
                clear_address       = 1'b1;
                clear_preview_timer = 1'b1;
                next_state          = memory_game_pkg::preview_show;
            end
            default: begin
                // idle and the three final states wait for play
                if (start) begin
                    next_state = memory_game_pkg::prepare;
                end
            end
        endcase
    end

    // ------------------------------------------------------------
    // Registered outcome levels
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset || start) begin
            won     <= 1'b0;
            lost    <= 1'b0;
            timeout <= 1'b0;
            ready   <= 1'b0;
        end else begin
            case (next_state)
                memory_game_pkg::won: begin
                    won   <= 1'b1;
                    ready <= 1'b1;
                end
                memory_game_pkg::lost: begin
                    lost  <= 1'b1;
                    ready <= 1'b1;
                end
                memory_game_pkg::timed_out: begin
                    lost    <= 1'b1;
                    timeout <= 1'b1;
                    ready   <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== hdl/memory_game_datapath.sv ====
// Buttons are not debounced; a press counts once, on the released-to-pressed edge
`timescale 1ns/100ps
`include "memory_game_config.svh"

module memory_game_datapath (
    input  logic                       clock,
    input  logic                       reset,
    input  memory_game_pkg::button_t   buttons,
    input  logic                       clear_address,
    input  logic                       count_address,
    input  logic                       clear_round,
    input  logic                       count_round,
    input  logic                       clear_press_timer,
    input  logic                       clear_preview_timer,
    input  logic                       store_press,
    input  logic                       preview,
    output logic                       press_seen,
    output logic                       press_match,
    output logic                       address_at_round,
    output logic                       last_round,
    output logic                       preview_on_done,
    output logic                       preview_off_done,
    output logic                       press_timeout,
    output memory_game_pkg::button_t   leds,
    output memory_game_pkg::address_t  address,
    output memory_game_pkg::round_t    round
);

    localparam int preview_period = `MG_PREVIEW_ON + `MG_PREVIEW_OFF;
    localparam int preview_width  = $clog2(preview_period);
    localparam int timeout_width  = $clog2(`MG_TIMEOUT + 1);

    localparam logic [preview_width-1:0] preview_on_last =
        preview_width'(`MG_PREVIEW_ON - 1);
    localparam logic [preview_width-1:0] preview_off_last =
        preview_width'(preview_period - 1);
    localparam logic [timeout_width-1:0] timeout_limit =
        timeout_width'(`MG_TIMEOUT);

    memory_game_pkg::button_t rom_entry;
    memory_game_pkg::button_t buttons_q;
    memory_game_pkg::button_t press_q;
    logic [preview_width-1:0] preview_count;
    logic [timeout_width-1:0] press_count;

    // ------------------------------------------------------------
    // Sequence ROM
    // ------------------------------------------------------------
    always_comb begin
        case (address)
            4'h0:    rom_entry = 4'b0001;
            4'h1:    rom_entry = 4'b0010;
            4'h2:    rom_entry = 4'b0100;
            4'h3:    rom_entry = 4'b1000;
            4'h4:    rom_entry = 4'b0010;
            4'h5:    rom_entry = 4'b0001;
            4'h6:    rom_entry = 4'b1000;
            4'h7:    rom_entry = 4'b0100;
            4'h8:    rom_entry = 4'b0100;
            4'h9:    rom_entry = 4'b1000;
            4'hA:    rom_entry = 4'b0001;
            4'hB:    rom_entry = 4'b0010;
            4'hC:    rom_entry = 4'b1000;
            4'hD:    rom_entry = 4'b0100;
            4'hE:    rom_entry = 4'b0010;
            default: rom_entry = 4'b0001;
        endcase
    end

    // ------------------------------------------------------------
    // Address and round counters
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset || clear_address) begin
            address <= '0;
        end else if (count_address) begin
            address <= address + 4'd1;
        end
    end

    // A new game starts in round 1
    always_ff @(posedge clock) begin
        if (reset) begin
            round <= '0;
        end else if (clear_round) begin
            round <= 4'd1;
        end else if (count_round) begin
            round <= round + 4'd1;
        end
    end

    assign address_at_round = (address == round - 4'd1);
    assign last_round       = (round == 4'(`MG_ROUNDS));

    // ------------------------------------------------------------
    // Press edge detection and press register
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            buttons_q  <= '0;
            press_seen <= 1'b0;
        end else begin
            buttons_q  <= buttons;
            press_seen <= (|buttons) & ~(|buttons_q);
        end
    end

    // buttons_q holds the value seen on the edge while press_seen is high
    always_ff @(posedge clock) begin
        if (store_press) begin
            press_q <= buttons_q;
        end
    end

    assign press_match = (press_q == rom_entry);

    // ------------------------------------------------------------
    // Timers
    // ------------------------------------------------------------

    // One period covers the lit phase followed by the dark gap
    always_ff @(posedge clock) begin
        if (reset || clear_preview_timer) begin
            preview_count <= '0;
        end else if (preview_count == preview_off_last) begin
            preview_count <= '0;
        end else begin
            preview_count <= preview_count + preview_width'(1);
        end
    end

    assign preview_on_done  = (preview_count == preview_on_last);
    assign preview_off_done = (preview_count == preview_off_last);

    // Saturates so the timeout flag holds
    always_ff @(posedge clock) begin
        if (reset || clear_press_timer) begin
            press_count <= '0;
        end else if (press_count != timeout_limit) begin
            press_count <= press_count + timeout_width'(1);
        end
    end

    assign press_timeout = (press_count == timeout_limit);

    // ------------------------------------------------------------
    // LED source
    // ------------------------------------------------------------
    always_comb begin
        if (!preview) begin
            leds = buttons;
        end else if (preview_count <= preview_on_last) begin
            leds = rom_entry;
        end else begin
            leds = '0;
        end
    end

endmodule

// ==== hdl/memory_game_pkg.sv ====
// Shared types only; the state encoding fits one hex digit for the debug display
package memory_game_pkg;

    // ------------------------------------------------------------
    // Board signals
    // ------------------------------------------------------------

    // One bit per button or LED, one-hot when valid
    typedef logic [3:0] button_t;

    // Index into the sixteen-entry sequence ROM
    typedef logic [3:0] address_t;

    // Current round, 1 up to the round count
    typedef logic [3:0] round_t;

    // Segments {g, f, e, d, c, b, a}, active low
    typedef logic [6:0] segments_t;

    // ------------------------------------------------------------
    // Control FSM states
    // ------------------------------------------------------------

    typedef enum logic [3:0] {
        idle         = 4'h0,
        prepare      = 4'h1,
        preview_show = 4'h2,
        preview_gap  = 4'h3,
        wait_press   = 4'h4,
        check        = 4'h5,
        next_entry   = 4'h6,
        next_round   = 4'h7,
        won          = 4'h8,
        lost         = 4'h9,
        timed_out    = 4'hA
    } state_t;

endpackage

// ==== memory_game.f ====
+incdir+hdl
hdl/memory_game_pkg.sv
hdl/hex_to_seven_segment.sv
hdl/memory_game_datapath.sv
hdl/memory_game_control.sv
hdl/memory_game.sv
tests/memory_game_tb.sv

// ==== tests/memory_game_tb.sv ====
// Run from the project root; the testdata file must list the ROM before any game
`timescale 1ns/100ps
`include "memory_game_config.svh"

module memory_game_tb;

    localparam int max_games   = 8;
    localparam int max_presses = 64;

    logic                       clock;
    logic                       reset;
    logic                       play;
    memory_game_pkg::button_t   buttons;
    logic                       won;
    logic                       lost;
    logic                       timeout;
    logic                       ready;
    memory_game_pkg::button_t   leds;
    memory_game_pkg::segments_t db_state;
    memory_game_pkg::segments_t db_address;
    memory_game_pkg::segments_t db_round;

    memory_game_pkg::button_t rom_value [16];
    logic [8*16-1:0]          game_name [max_games];
    logic [7:0]               game_outcome [max_games];
    int                       game_round [max_games];
    int                       game_first [max_games];
    int                       game_presses [max_games];
    memory_game_pkg::button_t press_value [max_presses];
    int                       press_gap [max_presses];
    int                       game_total;
    int                       press_total;
    int                       max_gap;
    int                       watchdog_cycles;
    int                       value_errors;
    int                       other_errors;
    string                    test_name;

    memory_game memory_game_i (
        .clock      (clock),
        .reset      (reset),
        .play       (play),
        .buttons    (buttons),
        .won        (won),
        .lost       (lost),
        .timeout    (timeout),
        .ready      (ready),
        .leds       (leds),
        .db_state   (db_state),
        .db_address (db_address),
        .db_round   (db_round)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ------------------------------------------------------------
    // Expected values and compare tasks
    // ------------------------------------------------------------

    // Lit segments {g..a} as active high, one per hex digit
    function automatic memory_game_pkg::segments_t segment_code(input int digit);
        logic [6:0] lit [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                                 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return ~lit[digit[3:0]];
    endfunction

    task automatic check_leds(input string what, input memory_game_pkg::button_t expected,
                              input memory_game_pkg::button_t actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_segments(input string what, input memory_game_pkg::segments_t expected,
                                  input memory_game_pkg::segments_t actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic report_problem(input string text);
        $display("ERROR %s: %s", test_name, text);
        other_errors++;
    endtask

    // ------------------------------------------------------------
    // Testdata reader
    // ------------------------------------------------------------
    task automatic read_testdata();
        int              fd;
        int              n;
        int              i;
        bit              done;
        logic [7:0]      kind;
        logic [8*80-1:0] line;
        fd = $fopen("tests/memory_game_testdata.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open tests/memory_game_testdata.txt");
            return;
        end
        done = 0;
        while (!done) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1) begin
                done = 1;
            end else if (kind == "#") begin
                n = $fgets(line, fd);
            end else if (kind == "M") begin
                for (i = 0; i < 16; i++) begin
                    n = $fscanf(fd, "%h", rom_value[i]);
                end
            end else if (kind == "G" && game_total < max_games) begin
                n = $fscanf(fd, "%s %c %d", game_name[game_total], game_outcome[game_total],
                            game_round[game_total]);
                game_first[game_total]   = press_total;
                game_presses[game_total] = 0;
                game_total++;
            end else if (kind == "P" && game_total > 0 && press_total < max_presses) begin
                n = $fscanf(fd, "%h %d", press_value[press_total], press_gap[press_total]);
                if (press_gap[press_total] > max_gap) begin
                    max_gap = press_gap[press_total];
                end
                game_presses[game_total-1]++;
                press_total++;
            end else begin
                report_problem("testdata file has a line that cannot be used");
                done = 1;
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // Game steps
    // ------------------------------------------------------------
    task automatic start_game();
        @(negedge clock);
        play = 1'b1;
        @(negedge clock);
        play = 1'b0;
        check_flag("won after play", 1'b0, won);
        check_flag("lost after play", 1'b0, lost);
        check_flag("timeout after play", 1'b0, timeout);
        check_flag("ready after play", 1'b0, ready);
    endtask

    // Each entry must light for exactly the on time, then go dark
    task automatic check_preview(input int r);
        int i;
        int cycles;
        int lit;
        for (i = 0; i < r; i++) begin
            cycles = 0;
            do begin
                @(negedge clock);
                cycles++;
            end while (leds === '0 && cycles < 2 * (`MG_PREVIEW_ON + `MG_PREVIEW_OFF));
            if (leds === '0) begin
                report_problem($sformatf("preview entry %0d of round %0d never lit", i, r));
                return;
            end
            check_leds($sformatf("preview round %0d entry %0d", r, i), rom_value[i], leds);
            lit = 0;
            while (leds !== '0 && lit <= `MG_PREVIEW_ON) begin
                lit++;
                @(negedge clock);
            end
            if (lit != `MG_PREVIEW_ON) begin
                report_problem($sformatf("preview entry %0d of round %0d lit for %0d cycles",
                                         i, r, lit));
            end
        end
    endtask

    task automatic wait_for_press_state(output bit reached);
        int cycles;
        reached = 0;
        cycles  = 0;
        while (!reached && !ready && cycles < 2 * `MG_TIMEOUT) begin
            @(negedge clock);
            reached = (db_state === segment_code(int'(memory_game_pkg::wait_press)));
            cycles++;
        end
        if (!reached && !ready) begin
            report_problem("the game never waited for a press");
        end
    endtask

    // A play pulse in the middle of a game must be ignored
    task automatic ignored_play();
        play = 1'b1;
        @(negedge clock);
        play = 1'b0;
        check_flag("ready after stray play", 1'b0, ready);
        check_segments("state after stray play",
                       segment_code(int'(memory_game_pkg::wait_press)), db_state);
    endtask

    task automatic press_buttons(input memory_game_pkg::button_t value, input int gap,
                                 output bit ended);
        int cycles;
        ended  = 0;
        cycles = 0;
        while (cycles < gap && !ready) begin
            @(negedge clock);
            cycles++;
        end
        if (ready) begin
            ended = 1;
            return;
        end
        buttons = value;
        @(negedge clock);
        check_leds("button echo", value, leds);
        buttons = '0;
    endtask

    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        while (!ready && cycles < `MG_TIMEOUT + 16) begin
            @(negedge clock);
            cycles++;
        end
        if (!ready) begin
            report_problem("ready never rose at the end of the game");
        end
    endtask

    task automatic play_game(input int g);
        int r;
        int e;
        int p;
        bit over;
        bit reached;
        test_name = $sformatf("%0s", game_name[g]);
        p    = game_first[g];
        over = (game_presses[g] == 0);
        r    = 1;
        start_game();
        while (!over && r <= `MG_ROUNDS) begin
            check_preview(r);
            for (e = 0; e < r && !over; e++) begin
                wait_for_press_state(reached);
                if (!reached) begin
                    over = 1;
                end else begin
                    // The address display shows the entry the player must press next
                    check_segments($sformatf("db_address round %0d entry %0d", r, e),
                                   segment_code(e), db_address);
                    if (r == 2 && e == 0) begin
                        ignored_play();
                    end
                    press_buttons(press_value[p], press_gap[p], over);
                    p++;
                    if (p == game_first[g] + game_presses[g]) begin
                        over = 1;
                    end
                end
            end
            r++;
        end
        wait_for_ready();
        check_flag("ready", 1'b1, ready);
        check_flag("won", game_outcome[g] == "W", won);
        check_flag("lost", game_outcome[g] != "W", lost);
        check_flag("timeout", game_outcome[g] == "T", timeout);
        check_segments("db_round", segment_code(game_round[g]), db_round);
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        int g;
        reset           = 1'b1;
        play            = 1'b0;
        buttons         = '0;
        value_errors    = 0;
        other_errors    = 0;
        game_total      = 0;
        press_total     = 0;
        max_gap         = 0;
        watchdog_cycles = 0;
        test_name       = "testdata";
        read_testdata();
        if (game_total == 0) begin
            report_problem("no games found in the testdata file");
        end
        // Reset and margin on top of the worst case of every game
        watchdog_cycles = game_total * 2 * (`MG_ROUNDS * `MG_ROUNDS
                          * (`MG_PREVIEW_ON + `MG_PREVIEW_OFF)
                          + max_gap * `MG_ROUNDS * `MG_ROUNDS + `MG_TIMEOUT) + 8 + 64;
        repeat (8) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        test_name = "reset";
        check_flag("won", 1'b0, won);
        check_flag("lost", 1'b0, lost);
        check_flag("timeout", 1'b0, timeout);
        check_flag("ready", 1'b0, ready);
        check_leds("leds", '0, leds);
        for (g = 0; g < game_total; g++) begin
            play_game(g);
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("ERROR: watchdog expired after %0d cycles, the games did not finish",
                 watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== tests/memory_game_testdata.txt ====
# M: sixteen ROM entries in hex, address 0 first
# G: game name, outcome (W won, L lost, T timed out), final round
# P: pressed buttons in hex, idle cycles in wait_press before the press
M 1 2 4 8 2 1 8 4 4 8 1 2 8 4 2 1
G full_win W 6
P 1 0
P 1 3
P 2 1
P 1 5
P 2 0
P 4 12
P 1 2
P 2 2
P 4 40
P 8 1
P 1 0
P 2 7
P 4 3
P 8 150
P 2 1
P 1 1
P 2 0
P 4 9
P 8 2
P 2 30
P 1 4
G wrong_second L 2
P 1 2
P 1 0
P 4 6
G timeout_third T 3
P 1 1
P 1 1
P 2 2
P 1 0
P 2 250
G wrong_fourth L 4
P 1 0
P 1 1
P 2 1
P 1 1
P 2 1
P 4 1
P 2 3
